// ==== src/mips_control_config.svh ====
// mips control unit configuration, field and control word widths
`ifndef MIPS_CONTROL_CONFIG_SVH
`define MIPS_CONTROL_CONFIG_SVH

// instruction fields
`define OPCODE_W 6      // instr[31:26]
`define FUNCT_W 6       // instr[5:0] for the special opcode
`define BRFUNC_W 5      // rt field, picks the regimm branch variant

// sequencer
`define STATE_W 3       // halt, fetch, decode, exec1, exec2

// alu
`define ALUOP_W 4       // see alu_op_e

// memory side
`define BE_W 4          // byte lanes of a 32 bit word
`define EXT_W 3         // load extend mode, msb set means sub-word load

// multiply/divide unit
`define MDOP_W 2        // mthi, mtlo, mult, div

`endif

// ==== src/mips_control_pkg.sv ====
// mips control package, encodings and control word structs shared by the control unit
`include "mips_control_config.svh"

package mips_control_pkg;

    typedef enum logic [`OPCODE_W-1:0] {
        OP_SPECIAL = 6'b000000,   // register format, funct decides
        OP_REGIMM  = 6'b000001,   // bltz and its link variants
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_LB      = 6'b100000,
        OP_LH      = 6'b100001,
        OP_LWL     = 6'b100010,   // not implemented, decodes as unknown
        OP_LW      = 6'b100011,
        OP_LBU     = 6'b100100,
        OP_LHU     = 6'b100101,
        OP_LWR     = 6'b100110,   // not implemented, decodes as unknown
        OP_SB      = 6'b101000,
        OP_SH      = 6'b101001,
        OP_SW      = 6'b101011
    } opcode_e;

    typedef enum logic [`FUNCT_W-1:0] {
        FN_SLL  = 6'b000000, FN_SRL  = 6'b000010, FN_SRA   = 6'b000011,
        FN_SLLV = 6'b000100, FN_SRLV = 6'b000110, FN_SRAV  = 6'b000111,
        FN_JR   = 6'b001000, FN_JALR = 6'b001001,
        FN_MFHI = 6'b010000, FN_MTHI = 6'b010001, FN_MFLO  = 6'b010010,
        FN_MTLO = 6'b010011, FN_MULT = 6'b011000, FN_MULTU = 6'b011001,
        FN_DIV  = 6'b011010, FN_DIVU = 6'b011011,
        FN_ADDU = 6'b100001, FN_SUBU = 6'b100011, FN_AND   = 6'b100100,
        FN_OR   = 6'b100101, FN_XOR  = 6'b100110, FN_SLT   = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    typedef enum logic [`STATE_W-1:0] {
        ST_HALT   = 3'd0,
        ST_FETCH  = 3'd1,
        ST_DECODE = 3'd2,
        ST_EXEC1  = 3'd3,
        ST_EXEC2  = 3'd4
    } state_e;

    typedef enum logic [`ALUOP_W-1:0] {
        ALU_ADD   = 4'b0000,
        ALU_SUB   = 4'b0001,   // also the beq compare
        ALU_FUNCT = 4'b0010,   // alu looks at the funct field itself
        ALU_AND   = 4'b0100,
        ALU_OR    = 4'b0101,
        ALU_XOR   = 4'b0110,
        ALU_SLT   = 4'b0111,
        ALU_NE    = 4'b1000,
        ALU_GTZ   = 4'b1001,
        ALU_LEZ   = 4'b1010,
        ALU_LTZ   = 4'b1011,
        ALU_SLTU  = 4'b1100
    } alu_op_e;

    typedef enum logic [`EXT_W-1:0] {
        EXT_NONE   = 3'b000,
        EXT_HALF_U = 3'b100,
        EXT_HALF_S = 3'b101,
        EXT_BYTE_U = 3'b110,
        EXT_BYTE_S = 3'b111
    } ext_e;

    typedef struct packed {
        logic [`OPCODE_W-1:0] opcode;
        logic [`FUNCT_W-1:0]  funct;
        logic [`BRFUNC_W-1:0] rt;
        logic [1:0]           align;   // low address bits for sub-word stores
    } instr_fields_t;

    typedef struct packed {
        logic r_type;
        logic arith;         // r-type funct that writes rd
        logic reg_jump;      // jr, jalr
        logic mult_div;
        logic imm_alu;
        logic lui;
        logic branch;
        logic branch_link;   // bltzal, bgezal
        logic load;
        logic store;
        logic jump;          // j, jal
        logic jal;
        logic known;         // opcode is one we implement
        logic st_byte;
        logic st_half;
        ext_e ext;
    } instr_class_t;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src;      // 1 selects the immediate
        logic    signed_imm;
    } alu_ctrl_t;

    typedef struct packed {
        logic [`BE_W-1:0] byteenable;
        logic             memread;
        logic             memwrite;
        ext_e             extend_op;
    } mem_ctrl_t;

    typedef struct packed {
        logic regdst;
        logic memtoreg;
        logic regwrite;
        logic hitoreg;
        logic lotoreg;
        logic link;          // write return address
        logic loadimmed;     // lui path
    } reg_ctrl_t;

    typedef struct packed {
        logic jump;
        logic branch;
        logic regtojump;
        logic pcwrite;
        logic pctoadd;       // pc drives the memory address
        logic inwrite;       // load the instruction register
    } pc_ctrl_t;

    typedef struct packed {
        logic              en;
        logic              is_signed;
        logic [`MDOP_W-1:0] op;
    } muldiv_ctrl_t;

endpackage

// ==== src/control_fsm.sv ====
// control fsm, five state sequencer with run start and memory stall
`timescale 1ns/1ns
`include "mips_control_config.svh"

module control_fsm
    import mips_control_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   run,
    input  logic   waitrequest,   // memory busy, hold the state
    output state_e state
);

    state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            ST_HALT: begin
                if (run) state_next = ST_FETCH;
            end
            ST_FETCH: begin
                if (!waitrequest) state_next = ST_DECODE;   // instruction word is back
            end
            ST_DECODE: begin
                state_next = ST_EXEC1;                     // never stalls
            end
            ST_EXEC1: begin
                if (!waitrequest) state_next = ST_EXEC2;
            end
            ST_EXEC2: begin
                if (!waitrequest) state_next = ST_FETCH;
            end
            default: begin
                state_next = ST_HALT;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_HALT;
        end else begin
            state <= state_next;
        end
    end

    // the register never holds one of the three unused codes
    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {ST_HALT, ST_FETCH, ST_DECODE, ST_EXEC1, ST_EXEC2})
        else $error("control_fsm reached illegal state %0d", state);

endmodule

// ==== src/instr_decoder.sv ====
// instruction decoder, opcode and funct to class flags and alu control
`timescale 1ns/1ns
`include "mips_control_config.svh"

module instr_decoder
    import mips_control_pkg::*;
(
    input  instr_fields_t instr,
    output instr_class_t  cls,
    output alu_ctrl_t     alu
);

    // rt codes of the regimm link variants
    localparam logic [`BRFUNC_W-1:0] RT_BLTZAL = 5'b10000;
    localparam logic [`BRFUNC_W-1:0] RT_BGEZAL = 5'b10001;

    always_comb begin
        cls            = '0;
        cls.ext        = EXT_NONE;
        alu.alu_op     = ALU_ADD;
        alu.alu_src    = 1'b0;
        alu.signed_imm = 1'b0;

        case (instr.opcode)
            OP_SPECIAL: begin
                cls.r_type = 1'b1;
                cls.arith  = instr.funct inside {FN_ADDU, FN_AND, FN_OR, FN_SLT, FN_SLTU,
                                                 FN_SUBU, FN_XOR, FN_SLL, FN_SRA, FN_SRL,
                                                 FN_SLLV, FN_SRAV, FN_SRLV, FN_MFHI,
                                                 FN_MFLO, FN_JALR};
                cls.reg_jump = instr.funct inside {FN_JR, FN_JALR};
                cls.mult_div = instr.funct inside {FN_MTHI, FN_MTLO, FN_MULT, FN_MULTU,
                                                   FN_DIV, FN_DIVU};
                alu.alu_op   = ALU_FUNCT;
            end

            // immediate alu group, all take the immediate operand
            OP_ADDIU: begin
                cls.imm_alu = 1'b1;
                alu.alu_src = 1'b1;
            end
            OP_SLTI: begin
                cls.imm_alu    = 1'b1;
                alu.alu_op     = ALU_SLT;
                alu.alu_src    = 1'b1;
                alu.signed_imm = 1'b1;   // only slti compares signed
            end
            OP_SLTIU: begin
                cls.imm_alu = 1'b1;
                alu.alu_op  = ALU_SLTU;
                alu.alu_src = 1'b1;
            end
            OP_ANDI: begin
                cls.imm_alu = 1'b1;
                alu.alu_op  = ALU_AND;
                alu.alu_src = 1'b1;
            end
            OP_ORI: begin
                cls.imm_alu = 1'b1;
                alu.alu_op  = ALU_OR;
                alu.alu_src = 1'b1;
            end
            OP_XORI: begin
                cls.imm_alu = 1'b1;
                alu.alu_op  = ALU_XOR;
                alu.alu_src = 1'b1;
            end
            OP_LUI: begin
                cls.lui     = 1'b1;
                alu.alu_src = 1'b1;
            end

            // two register branches compare rs with rt
            OP_BEQ: begin
                cls.branch = 1'b1;
                alu.alu_op = ALU_SUB;
            end
            OP_BNE: begin
                cls.branch = 1'b1;
                alu.alu_op = ALU_NE;
            end
            OP_BGTZ: begin
                cls.branch  = 1'b1;
                alu.alu_op  = ALU_GTZ;
                alu.alu_src = 1'b1;
            end
            OP_BLEZ: begin
                cls.branch  = 1'b1;
                alu.alu_op  = ALU_LEZ;
                alu.alu_src = 1'b1;
            end
            OP_REGIMM: begin
                cls.branch      = 1'b1;
                cls.branch_link = instr.rt inside {RT_BLTZAL, RT_BGEZAL};
                alu.alu_op      = ALU_LTZ;
                alu.alu_src     = 1'b1;
            end

            // loads and stores add the offset to rs
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
                cls.load    = 1'b1;
                alu.alu_src = 1'b1;
                case (instr.opcode)
                    OP_LB:   cls.ext = EXT_BYTE_S;
                    OP_LBU:  cls.ext = EXT_BYTE_U;
                    OP_LH:   cls.ext = EXT_HALF_S;
                    OP_LHU:  cls.ext = EXT_HALF_U;
                    default: cls.ext = EXT_NONE;    // lw takes the whole word
                endcase
            end
            OP_SB, OP_SH, OP_SW: begin
                cls.store   = 1'b1;
                cls.st_byte = instr.opcode == OP_SB;
                cls.st_half = instr.opcode == OP_SH;
                alu.alu_src = 1'b1;
            end

            OP_J: begin
                cls.jump = 1'b1;
            end
            OP_JAL: begin
                cls.jump = 1'b1;
                cls.jal  = 1'b1;
            end
            default: begin
            end
        endcase

        cls.known = cls.r_type | cls.imm_alu | cls.lui | cls.branch
                  | cls.load | cls.store | cls.jump;
    end

endmodule

// ==== src/datapath_ctrl.sv ====
// datapath control, alu, register file, pc and multiply/divide strobes per state
`timescale 1ns/1ns
`include "mips_control_config.svh"

module datapath_ctrl
    import mips_control_pkg::*;
(
    input  state_e        state,
    input  instr_class_t  cls,
    input  alu_ctrl_t     alu_in,
    input  instr_fields_t instr,
    input  logic          waitrequest,
    output alu_ctrl_t     alu,
    output reg_ctrl_t     regs,
    output pc_ctrl_t      pc,
    output muldiv_ctrl_t  md
);

    logic fetch;
    logic decode;
    logic exec1;
    logic exec2;
    logic writes_reg;   // instruction has a register result

    assign fetch  = state == ST_FETCH;
    assign decode = state == ST_DECODE;
    assign exec1  = state == ST_EXEC1;
    assign exec2  = state == ST_EXEC2;

    assign writes_reg = cls.arith | cls.imm_alu | cls.lui | cls.load
                      | cls.jal | cls.branch_link;

    always_comb begin
        alu  = '0;
        regs = '0;
        pc   = '0;
        md   = '0;

        if (fetch || decode) begin
            pc.pctoadd = 1'b1;     // pc addresses memory in both
            pc.inwrite = decode;   // capture the fetched word
        end else if (cls.known) begin
            // halt, exec1 and exec2 follow the opcode
            alu = alu_in;

            regs.regdst    = cls.r_type | cls.store;
            regs.memtoreg  = cls.load && instr.opcode == OP_LW;
            regs.regwrite  = exec2 & writes_reg;
            regs.hitoreg   = cls.r_type && instr.funct == FN_MFHI;
            regs.lotoreg   = cls.r_type && instr.funct == FN_MFLO;
            regs.link      = cls.jal | cls.branch_link
                           | (cls.r_type && instr.funct == FN_JALR);
            regs.loadimmed = cls.lui;

            pc.jump      = cls.jump | cls.reg_jump;
            pc.branch    = cls.branch;
            pc.regtojump = cls.reg_jump;
            pc.pcwrite   = exec2 & !waitrequest;   // last cycle of the instruction

            md.en        = cls.mult_div & exec1;   // one strobe per instruction
            md.is_signed = cls.r_type && instr.funct inside {FN_MULT, FN_DIV};
            if (cls.r_type) begin
                case (instr.funct)
                    FN_MTLO:           md.op = 2'b01;
                    FN_MULT, FN_MULTU: md.op = 2'b10;
                    FN_DIV, FN_DIVU:   md.op = 2'b11;
                    default:           md.op = 2'b00;   // mthi
                endcase
            end
        end
    end

    // a register result only lands once the sequencer is in exec2
    a_regwrite_exec2: assert property (@(state) regs.regwrite |-> state == ST_EXEC2)
        else $error("regwrite high in state %0d", state);

endmodule

// ==== src/mem_ctrl.sv ====
// memory control, read/write strobes, byte lanes and load extend mode
`timescale 1ns/1ns
`include "mips_control_config.svh"

module mem_ctrl
    import mips_control_pkg::*;
(
    input  state_e        state,
    input  instr_class_t  cls,
    input  instr_fields_t instr,
    output mem_ctrl_t     mem
);

    localparam logic [`BE_W-1:0] BE_ALL  = '1;
    localparam logic [`BE_W-1:0] BE_BYTE = 4'b1000;   // lane of address 0
    localparam logic [`BE_W-1:0] BE_HALF = 4'b1100;

    always_comb begin
        mem.byteenable = BE_ALL;
        mem.memread    = 1'b0;
        mem.memwrite   = 1'b0;
        mem.extend_op  = EXT_NONE;

        if (state == ST_FETCH) begin
            mem.memread = 1'b1;   // instruction read
        end else if (state != ST_DECODE) begin
            // avalon reads stall the cpu, so only ask in exec1
            mem.memread   = (state == ST_EXEC1) & (cls.load | cls.lui);
            mem.memwrite  = (state == ST_EXEC2) & cls.store;
            mem.extend_op = cls.ext;

            if (cls.st_byte) begin
                mem.byteenable = BE_BYTE >> instr.align;
            end else if (cls.st_half) begin
                mem.byteenable = BE_HALF >> instr.align;
            end
        end
    end

    // a single avalon transfer is either a read or a write
    a_rd_wr_excl: assert property (@(state) !(mem.memread && mem.memwrite))
        else $error("memread and memwrite both high in state %0d", state);

endmodule

// ==== src/mips_control.sv ====
// mips control unit top, sequencer plus decode and control word drivers
`timescale 1ns/1ns
`include "mips_control_config.svh"

module mips_control
    import mips_control_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          run,
    input  logic          waitrequest,
    input  instr_fields_t instr,
    output alu_ctrl_t     alu,
    output mem_ctrl_t     mem,
    output reg_ctrl_t     regs,
    output pc_ctrl_t      pc,
    output muldiv_ctrl_t  md
);

    state_e       state;
    instr_class_t cls;
    alu_ctrl_t    alu_dec;   // decoder alu fields before state forcing

    control_fsm i_control_fsm (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .waitrequest (waitrequest),
        .state       (state)
    );

    instr_decoder i_instr_decoder (
        .instr (instr),
        .cls   (cls),
        .alu   (alu_dec)
    );

    datapath_ctrl i_datapath_ctrl (
        .state       (state),
        .cls         (cls),
        .alu_in      (alu_dec),
        .instr       (instr),
        .waitrequest (waitrequest),
        .alu         (alu),
        .regs        (regs),
        .pc          (pc),
        .md          (md)
    );

    mem_ctrl i_mem_ctrl (
        .state (state),
        .cls   (cls),
        .instr (instr),
        .mem   (mem)
    );

endmodule

// ==== tests/control_model.svh ====
// reference model of the mips control unit, state sequence and expected control words
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

function automatic state_e seq_next(input state_e s, input logic go, input logic stall);
    case (s)
        ST_HALT:   return go ? ST_FETCH : ST_HALT;
        ST_FETCH:  return stall ? ST_FETCH : ST_DECODE;
        ST_DECODE: return ST_EXEC1;   // decode never waits
        ST_EXEC1:  return stall ? ST_EXEC1 : ST_EXEC2;
        default:   return stall ? ST_EXEC2 : ST_FETCH;
    endcase
endfunction

function automatic logic is_load(input logic [`OPCODE_W-1:0] op);
    return op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
endfunction

function automatic logic is_store(input logic [`OPCODE_W-1:0] op);
    return op inside {OP_SB, OP_SH, OP_SW};
endfunction

// halt and exec states follow a listed opcode, everything else is a fixed word
function automatic logic active(input state_e s, input instr_fields_t f);
    return s inside {ST_HALT, ST_EXEC1, ST_EXEC2}
        && (f.opcode inside {OP_SPECIAL, OP_REGIMM, OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ,
                             OP_BGTZ, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI,
                             OP_LUI} || is_load(f.opcode) || is_store(f.opcode));
endfunction

function automatic alu_ctrl_t alu_expected(input state_e s, input instr_fields_t f);
    alu_ctrl_t a;
    a = '0;
    if (!active(s, f)) return a;
    case (f.opcode)
        OP_SPECIAL:  a.alu_op = ALU_FUNCT;
        OP_SLTI:     a = '{ALU_SLT, 1'b1, 1'b1};
        OP_SLTIU:    a = '{ALU_SLTU, 1'b1, 1'b0};
        OP_ANDI:     a = '{ALU_AND, 1'b1, 1'b0};
        OP_ORI:      a = '{ALU_OR, 1'b1, 1'b0};
        OP_XORI:     a = '{ALU_XOR, 1'b1, 1'b0};
        OP_BEQ:      a.alu_op = ALU_SUB;
        OP_BNE:      a.alu_op = ALU_NE;
        OP_BGTZ:     a = '{ALU_GTZ, 1'b1, 1'b0};
        OP_BLEZ:     a = '{ALU_LEZ, 1'b1, 1'b0};
        OP_REGIMM:   a = '{ALU_LTZ, 1'b1, 1'b0};
        OP_J, OP_JAL: a.alu_op = ALU_ADD;
        default:     a = '{ALU_ADD, 1'b1, 1'b0};   // addiu, lui, base plus offset
    endcase
    return a;
endfunction

function automatic mem_ctrl_t mem_expected(input state_e s, input instr_fields_t f);
    mem_ctrl_t m;
    m.byteenable = 4'b1111;
    m.memread    = (s == ST_FETCH);
    m.memwrite   = 1'b0;
    m.extend_op  = EXT_NONE;
    if (!active(s, f)) return m;
    m.memread  = (s == ST_EXEC1) && (is_load(f.opcode) || f.opcode == OP_LUI);
    m.memwrite = (s == ST_EXEC2) && is_store(f.opcode);
    case (f.opcode)
        OP_LB:   m.extend_op = EXT_BYTE_S;
        OP_LBU:  m.extend_op = EXT_BYTE_U;
        OP_LH:   m.extend_op = EXT_HALF_S;
        OP_LHU:  m.extend_op = EXT_HALF_U;
        OP_SB:   m.byteenable = 4'b1000 >> f.align;
        OP_SH:   m.byteenable = 4'b1100 >> f.align;
        default: ;
    endcase
    return m;
endfunction

function automatic reg_ctrl_t regs_expected(input state_e s, input instr_fields_t f);
    reg_ctrl_t r;
    logic      rtype;
    logic      blink;
    logic      result;
    r = '0;
    if (!active(s, f)) return r;
    rtype  = (f.opcode == OP_SPECIAL);
    blink  = (f.opcode == OP_REGIMM) && (f.rt inside {5'b10000, 5'b10001});
    result = (rtype && f.funct inside {FN_ADDU, FN_AND, FN_OR, FN_SLT, FN_SLTU, FN_SUBU,
                                       FN_XOR, FN_SLL, FN_SRA, FN_SRL, FN_SLLV, FN_SRAV,
                                       FN_SRLV, FN_MFHI, FN_MFLO, FN_JALR})
           || f.opcode inside {OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI}
           || is_load(f.opcode) || f.opcode == OP_JAL || blink;
    r.regdst    = rtype || is_store(f.opcode);
    r.memtoreg  = (f.opcode == OP_LW);
    r.regwrite  = (s == ST_EXEC2) && result;
    r.hitoreg   = rtype && f.funct == FN_MFHI;
    r.lotoreg   = rtype && f.funct == FN_MFLO;
    r.link      = (f.opcode == OP_JAL) || blink || (rtype && f.funct == FN_JALR);
    r.loadimmed = (f.opcode == OP_LUI);
    return r;
endfunction

function automatic pc_ctrl_t pc_expected(input state_e s, input instr_fields_t f,
                                         input logic stall);
    pc_ctrl_t p;
    logic     regj;
    p = '0;
    if (s == ST_FETCH || s == ST_DECODE) begin
        p.pctoadd = 1'b1;
        p.inwrite = (s == ST_DECODE);
        return p;
    end
    if (!active(s, f)) return p;
    regj        = (f.opcode == OP_SPECIAL) && (f.funct inside {FN_JR, FN_JALR});
    p.jump      = (f.opcode inside {OP_J, OP_JAL}) || regj;
    p.branch    = f.opcode inside {OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ, OP_REGIMM};
    p.regtojump = regj;
    p.pcwrite   = (s == ST_EXEC2) && !stall;
    return p;
endfunction

function automatic muldiv_ctrl_t md_expected(input state_e s, input instr_fields_t f);
    muldiv_ctrl_t m;
    m = '0;
    if (!active(s, f) || f.opcode != OP_SPECIAL) return m;
    m.en = (s == ST_EXEC1)
        && (f.funct inside {FN_MTHI, FN_MTLO, FN_MULT, FN_MULTU, FN_DIV, FN_DIVU});
    m.is_signed = f.funct inside {FN_MULT, FN_DIV};
    case (f.funct)
        FN_MTLO:           m.op = 2'b01;
        FN_MULT, FN_MULTU: m.op = 2'b10;
        FN_DIV, FN_DIVU:   m.op = 2'b11;
        default:           m.op = 2'b00;
    endcase
    return m;
endfunction

`endif

// ==== tests/tb_mips_control.sv ====
// testbench for the mips control unit that checks seeded random instructions against a model
`timescale 1ns/1ns
`include "mips_control_config.svh"

module tb_mips_control
    import mips_control_pkg::*;
();

    localparam int KIND_RTYPE    = 0;
    localparam int KIND_IMM      = 1;
    localparam int KIND_MEM      = 2;
    localparam int KIND_UNLISTED = 3;
    localparam int KIND_MIX      = 4;
    localparam int RUN_INSTRS    = 60;

    localparam logic [`FUNCT_W-1:0] RTYPE_FNS [23] = '{
        FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_JR, FN_JALR, FN_MFHI,
        FN_MTHI, FN_MFLO, FN_MTLO, FN_MULT, FN_MULTU, FN_DIV, FN_DIVU, FN_ADDU,
        FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU};
    localparam logic [`OPCODE_W-1:0] IMM_OPS [14] = '{
        OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
        OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ, OP_REGIMM, OP_J, OP_JAL};
    localparam logic [`OPCODE_W-1:0] MEM_OPS [8] = '{
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW};
    localparam logic [`OPCODE_W-1:0] OTHER_OPS [8] = '{   // nothing here is decoded
        OP_LWL, OP_LWR, 6'b001000, 6'b010000, 6'b011111, 6'b101010, 6'b110011, 6'b111111};

    logic          clk;
    logic          rst;
    logic          run;
    logic          waitrequest;
    instr_fields_t instr;
    alu_ctrl_t     alu;
    mem_ctrl_t     mem;
    reg_ctrl_t     regs;
    pc_ctrl_t      pc;
    muldiv_ctrl_t  md;

    state_e      exp_state;   // model copy of the sequencer
    int          checks;
    int          errors;
    int          test_errors;

    `include "control_model.svh"

    mips_control i_mips_control (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .waitrequest (waitrequest),
        .instr       (instr),
        .alu         (alu),
        .mem         (mem),
        .regs        (regs),
        .pc          (pc),
        .md          (md)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic show_mismatch(input string name, input string field,
                                 input logic [31:0] exp_v, input logic [31:0] act_v);
        $display("Mismatch %s %s expected %h actual %h", name, field, exp_v, act_v);
        errors++;
        test_errors++;
    endtask

    task automatic flag_failure(input string name, input string what);
        $display("Error in %s: %s", name, what);
        errors++;
        test_errors++;
    endtask

    task automatic test_done(input string name);
        $display("test %-16s %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    function automatic instr_fields_t pick_instr(input int kind);
        instr_fields_t f;
        int            k;
        logic [4:0]    i5;
        logic [3:0]    i4;
        logic [2:0]    i3;
        k       = (kind == KIND_MIX) ? int'($urandom_range(3)) : kind;
        f.funct = 6'($urandom);
        f.rt    = 5'($urandom);
        f.align = 2'($urandom);
        i3      = 3'($urandom);
        case (k)
            KIND_RTYPE: begin
                f.opcode = OP_SPECIAL;
                i5       = 5'($urandom_range(22));
                if ($urandom_range(3) != 0) f.funct = RTYPE_FNS[i5];   // mostly named functs
            end
            KIND_IMM: begin
                i4       = 4'($urandom_range(13));
                f.opcode = IMM_OPS[i4];
                if ($urandom_range(1) == 0) f.rt = {4'b1000, 1'($urandom)};   // link rts
            end
            KIND_MEM: f.opcode = MEM_OPS[i3];
            default:  f.opcode = OTHER_OPS[i3];
        endcase
        return f;
    endfunction

    // compare every output against the model at the falling edge
    task automatic check_cycle(input string name);
        alu_ctrl_t    e_alu;
        mem_ctrl_t    e_mem;
        reg_ctrl_t    e_regs;
        pc_ctrl_t     e_pc;
        muldiv_ctrl_t e_md;
        e_alu  = alu_expected(exp_state, instr);
        e_mem  = mem_expected(exp_state, instr);
        e_regs = regs_expected(exp_state, instr);
        e_pc   = pc_expected(exp_state, instr, waitrequest);
        e_md   = md_expected(exp_state, instr);
        checks++;
        assert (i_mips_control.state === exp_state)
            else show_mismatch(name, "state", 32'(exp_state), 32'(i_mips_control.state));
        assert (alu === e_alu) else show_mismatch(name, "alu", 32'(e_alu), 32'(alu));
        assert (mem === e_mem) else show_mismatch(name, "mem", 32'(e_mem), 32'(mem));
        assert (regs === e_regs) else show_mismatch(name, "regs", 32'(e_regs), 32'(regs));
        assert (pc === e_pc) else show_mismatch(name, "pc", 32'(e_pc), 32'(pc));
        assert (md === e_md) else show_mismatch(name, "md", 32'(e_md), 32'(md));
        assert (!pc.pcwrite || (exp_state == ST_EXEC2 && !waitrequest))
            else flag_failure(name, "pcwrite high outside exec2 or during a stall");
        assert (pc.inwrite == (exp_state == ST_DECODE))
            else flag_failure(name, "inwrite does not follow the decode state");
    endtask

    task automatic check_idle();
        int   cycles;
        logic seen;
        for (int i = 0; i < 10; i++) begin
            #2;
            instr       = pick_instr(KIND_MIX);
            waitrequest = ($urandom_range(2) == 0);
            @(negedge clk);
            check_cycle("reset_idle");
            assert (!(mem.memread || mem.memwrite || regs.regwrite || pc.inwrite
                      || pc.pcwrite || md.en))
                else flag_failure("reset_idle", "strobe active while halted");
            exp_state = seq_next(exp_state, run, waitrequest);
            @(posedge clk);
        end
        #2;
        run         = 1'b1;
        waitrequest = 1'b1;   // keep the first fetch waiting
        @(negedge clk);
        check_cycle("reset_idle");
        exp_state = seq_next(exp_state, run, waitrequest);
        cycles    = 0;
        seen      = 1'b0;
        while (!seen && cycles < 8) begin
            @(posedge clk);
            @(negedge clk);
            cycles++;
            seen = mem.memread && pc.pctoadd && !pc.inwrite;
        end
        if (!seen) begin
            flag_failure("reset_idle", "timeout waiting for the first fetch");
        end else begin
            assert (cycles == 1)
                else show_mismatch("reset_idle", "fetch latency", 1, 32'(cycles));
            check_cycle("reset_idle");
        end
        exp_state = seq_next(exp_state, run, waitrequest);
        @(posedge clk);
        test_done("reset_idle");
    endtask

    // runs until count instructions retire in the model with a new instr on each fetch
    task automatic run_instrs(input string name, input int kind, input int count);
        int done;
        int cycles;
        int limit;
        done   = 0;
        cycles = 0;
        limit  = count * 40;
        while (done < count && cycles < limit) begin
            #2;
            if (exp_state == ST_FETCH) instr = pick_instr(kind);
            waitrequest = ($urandom_range(2) == 0);   // busy about a third of the time
            @(negedge clk);
            check_cycle(name);
            if (exp_state == ST_EXEC2 && !waitrequest) done++;
            exp_state = seq_next(exp_state, run, waitrequest);
            cycles++;
            @(posedge clk);
        end
        if (done < count) flag_failure(name, "timeout before all instructions completed");
        test_done(name);
    endtask

    initial begin
        rst         = 1'b1;
        run         = 1'b0;
        waitrequest = 1'b0;
        instr       = '0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        exp_state   = ST_HALT;
        void'($urandom(53));
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);

        check_idle();
        run_instrs("random_sequence", KIND_MIX, RUN_INSTRS);
        run_instrs("rtype_decode", KIND_RTYPE, RUN_INSTRS);
        run_instrs("imm_branch_jump", KIND_IMM, RUN_INSTRS);
        run_instrs("load_store", KIND_MEM, RUN_INSTRS);
        run_instrs("unlisted_opcode", KIND_UNLISTED, 30);

        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== mips_control.f ====
+incdir+src
+incdir+tests
src/mips_control_pkg.sv
src/control_fsm.sv
src/instr_decoder.sv
src/datapath_ctrl.sv
src/mem_ctrl.sv
src/mips_control.sv
tests/tb_mips_control.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the mips control testbench with verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -f mips_control.f \
    --top-module tb_mips_control -o tb_mips_control
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_mips_control > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$log"; then
    exit 1
fi
exit 0
